// ==== hw/execute_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module execute_unit (
  input  wire                    clk,
  input  wire                    reset,
  // From decode
  input  wire                    i_ex_valid,
  input  wire rv_pkg::thread_t   i_ex_thread,
  input  wire rv_pkg::word_t     i_ex_pc,
  input  wire rv_pkg::reg_idx_t  i_ex_rd,
  input  wire                    i_ex_we,
  input  wire rv_pkg::alu_op_t   i_ex_alu_op,
  input  wire                    i_ex_use_imm,
  input  wire rv_pkg::wb_sel_t   i_ex_wb_sel,
  input  wire rv_pkg::br_cond_t  i_ex_br,
  input  wire                    i_ex_jal,
  input  wire rv_pkg::word_t     i_ex_imm,
  input  wire rv_pkg::word_t     i_ex_op_a,
  input  wire rv_pkg::word_t     i_ex_op_b,
  // Register writeback
  output logic                   o_wb_en,
  output rv_pkg::thread_t        o_wb_thread,
  output rv_pkg::reg_idx_t       o_wb_addr,
  output rv_pkg::word_t          o_wb_data,
  // Next PC for the same thread
  output logic                   o_pc_wr_en,
  output rv_pkg::thread_t        o_pc_wr_thread,
  output rv_pkg::word_t          o_pc_wr_data
);

  rv_pkg::word_t   alu_b;
  rv_pkg::word_t   alu_res;
  rv_pkg::word_t   pc_plus4;
  rv_pkg::word_t   pc_target;
  rv_pkg::word_t   next_pc;
  logic            br_eq;
  logic            br_lt;
  logic            br_taken;
  rv_pkg::thread_t wb_thread;

  // --------------------
  // ALU
  assign alu_b = i_ex_use_imm ? i_ex_imm : i_ex_op_b;

  always_comb begin
    case (i_ex_alu_op)
      rv_pkg::ALU_ADD:  alu_res = i_ex_op_a + alu_b;
      rv_pkg::ALU_SUB:  alu_res = i_ex_op_a - alu_b;
      rv_pkg::ALU_AND:  alu_res = i_ex_op_a & alu_b;
      rv_pkg::ALU_OR:   alu_res = i_ex_op_a | alu_b;
      rv_pkg::ALU_XOR:  alu_res = i_ex_op_a ^ alu_b;
      rv_pkg::ALU_SLT:  alu_res = rv_pkg::word_t'($signed(i_ex_op_a) < $signed(alu_b));
      rv_pkg::ALU_SLTU: alu_res = rv_pkg::word_t'(i_ex_op_a < alu_b);
      // LUI immediate straight through
      default:          alu_res = alu_b;
    endcase
  end

  // --------------------
  // Branch compare, always on the two registers
  assign br_eq = (i_ex_op_a == i_ex_op_b);
  assign br_lt = ($signed(i_ex_op_a) < $signed(i_ex_op_b));

  always_comb begin
    case (i_ex_br)
      rv_pkg::BR_EQ: br_taken = br_eq;
      rv_pkg::BR_NE: br_taken = !br_eq;
      rv_pkg::BR_LT: br_taken = br_lt;
      rv_pkg::BR_GE: br_taken = !br_lt;
      default:       br_taken = 1'b0;
    endcase
  end

  // Next PC, also the JAL link value
  assign pc_plus4  = i_ex_pc + `RV_XLEN'(4);
  assign pc_target = i_ex_pc + i_ex_imm;
  assign next_pc   = (i_ex_jal || br_taken) ? pc_target : pc_plus4;

  // --------------------
  // Writeback registers
  always_ff @(posedge clk) begin
    if (reset) begin
      o_wb_en    <= 1'b0;
      o_pc_wr_en <= 1'b0;
      wb_thread  <= '0;
    end else begin
      o_wb_en    <= i_ex_we;
      // Every valid slot moves its thread's PC, no-ops included
      o_pc_wr_en <= i_ex_valid;
      wb_thread  <= i_ex_thread;
    end
  end

  always_ff @(posedge clk) begin
    o_wb_addr    <= i_ex_rd;
    o_wb_data    <= (i_ex_wb_sel == rv_pkg::WB_LINK) ? pc_plus4 : alu_res;
    o_pc_wr_data <= next_pc;
  end

  // Register and PC writes belong to the same thread
  assign o_wb_thread    = wb_thread;
  assign o_pc_wr_thread = wb_thread;

endmodule

`default_nettype wire

// ==== hw/instr_decoder.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module instr_decoder (
  input  wire                    clk,
  input  wire                    reset,
  // Fetch slot and instruction
  input  wire                    i_valid,
  input  wire rv_pkg::thread_t   i_thread,
  input  wire rv_pkg::word_t     i_pc,
  input  wire rv_pkg::word_t     i_instr,
  // Register file
  input  wire rv_pkg::word_t     i_rs1_data,
  input  wire rv_pkg::word_t     i_rs2_data,
  output rv_pkg::reg_idx_t       o_rs1,
  output rv_pkg::reg_idx_t       o_rs2,
  // Execute stage
  output logic                   o_ex_valid,
  output rv_pkg::thread_t        o_ex_thread,
  output rv_pkg::word_t          o_ex_pc,
  output rv_pkg::reg_idx_t       o_ex_rd,
  output logic                   o_ex_we,
  output rv_pkg::alu_op_t        o_ex_alu_op,
  output logic                   o_ex_use_imm,
  output rv_pkg::wb_sel_t        o_ex_wb_sel,
  output rv_pkg::br_cond_t       o_ex_br,
  output logic                   o_ex_jal,
  output rv_pkg::word_t          o_ex_imm,
  output rv_pkg::word_t          o_ex_op_a,
  output rv_pkg::word_t          o_ex_op_b
);

  rv_pkg::opcode_t  opcode;
  logic [2:0]       funct3;
  logic [6:0]       funct7;
  rv_pkg::reg_idx_t rd;
  rv_pkg::word_t    imm_i;
  rv_pkg::word_t    imm_b;
  rv_pkg::word_t    imm_u;
  rv_pkg::word_t    imm_j;

  logic             dec_we;
  rv_pkg::alu_op_t  dec_alu_op;
  logic             dec_use_imm;
  rv_pkg::wb_sel_t  dec_wb_sel;
  rv_pkg::br_cond_t dec_br;
  logic             dec_jal;
  rv_pkg::word_t    dec_imm;

  // --------------------
  // Instruction fields
  assign opcode = rv_pkg::opcode_t'(i_instr[6:0]);
  assign rd     = i_instr[11:7];
  assign funct3 = i_instr[14:12];
  assign o_rs1  = i_instr[19:15];
  assign o_rs2  = i_instr[24:20];
  assign funct7 = i_instr[31:25];

  // Immediates, sign extended to the word
  assign imm_i = rv_pkg::word_t'($signed(i_instr[31:20]));
  assign imm_b = rv_pkg::word_t'($signed({i_instr[31], i_instr[7], i_instr[30:25],
                                          i_instr[11:8], 1'b0}));
  assign imm_u = rv_pkg::word_t'($signed({i_instr[31:12], 12'b0}));
  assign imm_j = rv_pkg::word_t'($signed({i_instr[31], i_instr[19:12], i_instr[20],
                                          i_instr[30:21], 1'b0}));

  // --------------------
  // Control decode
  // Anything outside the kept set falls through as a no-op
  always_comb begin
    dec_we      = 1'b0;
    dec_alu_op  = rv_pkg::ALU_ADD;
    dec_use_imm = 1'b0;
    dec_wb_sel  = rv_pkg::WB_ALU;
    dec_br      = rv_pkg::BR_NONE;
    dec_jal     = 1'b0;
    dec_imm     = imm_i;
    case (opcode)
      rv_pkg::OPC_OP: begin
        // Base funct7 only, SUB is the one alternate form
        if (funct7 == 7'b0000000 || (funct7 == 7'b0100000 && funct3 == 3'b000)) begin
          dec_we = 1'b1;
          case (funct3)
            3'b000:  dec_alu_op = funct7[5] ? rv_pkg::ALU_SUB : rv_pkg::ALU_ADD;
            3'b010:  dec_alu_op = rv_pkg::ALU_SLT;
            3'b011:  dec_alu_op = rv_pkg::ALU_SLTU;
            3'b100:  dec_alu_op = rv_pkg::ALU_XOR;
            3'b110:  dec_alu_op = rv_pkg::ALU_OR;
            3'b111:  dec_alu_op = rv_pkg::ALU_AND;
            // Shifts
            default: dec_we = 1'b0;
          endcase
        end
      end
      rv_pkg::OPC_OP_IMM: begin
        dec_we      = 1'b1;
        dec_use_imm = 1'b1;
        case (funct3)
          3'b000:  dec_alu_op = rv_pkg::ALU_ADD;
          3'b010:  dec_alu_op = rv_pkg::ALU_SLT;
          3'b011:  dec_alu_op = rv_pkg::ALU_SLTU;
          3'b100:  dec_alu_op = rv_pkg::ALU_XOR;
          3'b110:  dec_alu_op = rv_pkg::ALU_OR;
          3'b111:  dec_alu_op = rv_pkg::ALU_AND;
          // Shift immediates
          default: dec_we = 1'b0;
        endcase
      end
      rv_pkg::OPC_LUI: begin
        dec_we      = 1'b1;
        dec_alu_op  = rv_pkg::ALU_PASS_B;
        dec_use_imm = 1'b1;
        dec_imm     = imm_u;
      end
      rv_pkg::OPC_JAL: begin
        dec_we     = 1'b1;
        dec_jal    = 1'b1;
        dec_wb_sel = rv_pkg::WB_LINK;
        dec_imm    = imm_j;
      end
      rv_pkg::OPC_BRANCH: begin
        dec_imm = imm_b;
        case (funct3)
          3'b000:  dec_br = rv_pkg::BR_EQ;
          3'b001:  dec_br = rv_pkg::BR_NE;
          3'b100:  dec_br = rv_pkg::BR_LT;
          3'b101:  dec_br = rv_pkg::BR_GE;
          // Unsigned branches not kept
          default: dec_br = rv_pkg::BR_NONE;
        endcase
      end
      default: dec_we = 1'b0;
    endcase
  end

  // --------------------
  // Decode/execute boundary
  // Enables only count for a valid slot, rd of x0 never writes
  always_ff @(posedge clk) begin
    if (reset) begin
      o_ex_valid  <= 1'b0;
      o_ex_thread <= '0;
      o_ex_we     <= 1'b0;
      o_ex_jal    <= 1'b0;
      o_ex_br     <= rv_pkg::BR_NONE;
    end else begin
      o_ex_valid  <= i_valid;
      o_ex_thread <= i_thread;
      o_ex_we     <= i_valid && dec_we && (rd != '0);
      o_ex_jal    <= i_valid && dec_jal;
      o_ex_br     <= i_valid ? dec_br : rv_pkg::BR_NONE;
    end
  end

  // Payload, register operands captured here
  always_ff @(posedge clk) begin
    o_ex_pc      <= i_pc;
    o_ex_rd      <= rd;
    o_ex_alu_op  <= dec_alu_op;
    o_ex_use_imm <= dec_use_imm;
    o_ex_wb_sel  <= dec_wb_sel;
    o_ex_imm     <= dec_imm;
    o_ex_op_a    <= i_rs1_data;
    o_ex_op_b    <= i_rs2_data;
  end

endmodule

`default_nettype wire

// ==== hw/riscv_barrel_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module riscv_barrel_core (
  input  wire                    clk,
  input  wire                    reset,
  // Instruction ROM, synchronous, outside the core
  input  wire rv_pkg::word_t     i_rom_instr,
  output logic                   o_rom_en,
  output rv_pkg::thread_t        o_rom_thread,
  output rv_pkg::rom_addr_t      o_rom_addr,
  // Writeback, for debug
  output logic                   o_wb_en,
  output rv_pkg::thread_t        o_wb_thread,
  output rv_pkg::reg_idx_t       o_wb_addr,
  output rv_pkg::word_t          o_wb_data
);

  // Fetch slot
  logic             slot_valid;
  rv_pkg::thread_t  slot_thread;
  rv_pkg::word_t    slot_pc;

  // Register file reads
  rv_pkg::reg_idx_t rs1;
  rv_pkg::reg_idx_t rs2;
  rv_pkg::word_t    rs1_data;
  rv_pkg::word_t    rs2_data;

  // Decode to execute
  logic             ex_valid;
  rv_pkg::thread_t  ex_thread;
  rv_pkg::word_t    ex_pc;
  rv_pkg::reg_idx_t ex_rd;
  logic             ex_we;
  rv_pkg::alu_op_t  ex_alu_op;
  logic             ex_use_imm;
  rv_pkg::wb_sel_t  ex_wb_sel;
  rv_pkg::br_cond_t ex_br;
  logic             ex_jal;
  rv_pkg::word_t    ex_imm;
  rv_pkg::word_t    ex_op_a;
  rv_pkg::word_t    ex_op_b;

  // Next PC back to fetch
  logic             pc_wr_en;
  rv_pkg::thread_t  pc_wr_thread;
  rv_pkg::word_t    pc_wr_data;

  // --------------------
  // Fetch, cycle 0
  thread_fetch u_fetch (
    .clk            (clk),
    .reset          (reset),
    .i_pc_wr_en     (pc_wr_en),
    .i_pc_wr_thread (pc_wr_thread),
    .i_pc_wr_data   (pc_wr_data),
    .o_rom_en       (o_rom_en),
    .o_rom_thread   (o_rom_thread),
    .o_rom_addr     (o_rom_addr),
    .o_slot_valid   (slot_valid),
    .o_slot_thread  (slot_thread),
    .o_slot_pc      (slot_pc)
  );

  // Read in decode, written from writeback
  thread_regfile u_regfile (
    .clk         (clk),
    .i_rd_thread (slot_thread),
    .i_rs1       (rs1),
    .i_rs2       (rs2),
    .i_wr_en     (o_wb_en),
    .i_wr_thread (o_wb_thread),
    .i_wr_addr   (o_wb_addr),
    .i_wr_data   (o_wb_data),
    .o_rs1_data  (rs1_data),
    .o_rs2_data  (rs2_data)
  );

  // --------------------
  // Decode, cycle 1
  instr_decoder u_decoder (
    .clk          (clk),
    .reset        (reset),
    .i_valid      (slot_valid),
    .i_thread     (slot_thread),
    .i_pc         (slot_pc),
    .i_instr      (i_rom_instr),
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .o_rs1        (rs1),
    .o_rs2        (rs2),
    .o_ex_valid   (ex_valid),
    .o_ex_thread  (ex_thread),
    .o_ex_pc      (ex_pc),
    .o_ex_rd      (ex_rd),
    .o_ex_we      (ex_we),
    .o_ex_alu_op  (ex_alu_op),
    .o_ex_use_imm (ex_use_imm),
    .o_ex_wb_sel  (ex_wb_sel),
    .o_ex_br      (ex_br),
    .o_ex_jal     (ex_jal),
    .o_ex_imm     (ex_imm),
    .o_ex_op_a    (ex_op_a),
    .o_ex_op_b    (ex_op_b)
  );

  // Execute, cycle 2, writeback visible in cycle 3
  execute_unit u_execute (
    .clk            (clk),
    .reset          (reset),
    .i_ex_valid     (ex_valid),
    .i_ex_thread    (ex_thread),
    .i_ex_pc        (ex_pc),
    .i_ex_rd        (ex_rd),
    .i_ex_we        (ex_we),
    .i_ex_alu_op    (ex_alu_op),
    .i_ex_use_imm   (ex_use_imm),
    .i_ex_wb_sel    (ex_wb_sel),
    .i_ex_br        (ex_br),
    .i_ex_jal       (ex_jal),
    .i_ex_imm       (ex_imm),
    .i_ex_op_a      (ex_op_a),
    .i_ex_op_b      (ex_op_b),
    .o_wb_en        (o_wb_en),
    .o_wb_thread    (o_wb_thread),
    .o_wb_addr      (o_wb_addr),
    .o_wb_data      (o_wb_data),
    .o_pc_wr_en     (pc_wr_en),
    .o_pc_wr_thread (pc_wr_thread),
    .o_pc_wr_data   (pc_wr_data)
  );

endmodule

`default_nettype wire

// ==== hw/rv_defs.svh ====
`ifndef RV_DEFS_SVH
`define RV_DEFS_SVH

// Hardware threads
// Power of two and at least 4, so a thread's writeback
// always lands before that thread is fetched again
`define RV_NUM_THREADS 4

// Data and PC word width
`define RV_XLEN 32

// Word address width of one thread's ROM region
`define RV_ROM_AW 6

`endif

// ==== hw/rv_pkg.sv ====
`default_nettype none

`include "rv_defs.svh"

package rv_pkg;

  // Basic words and indices
  typedef logic [`RV_XLEN-1:0] word_t;
  typedef logic [4:0] reg_idx_t;
  typedef logic [$clog2(`RV_NUM_THREADS)-1:0] thread_t;
  typedef logic [`RV_ROM_AW-1:0] rom_addr_t;

  // --------------------
  // ALU operations, PASS_B serves LUI
  typedef enum logic [2:0] {
    ALU_ADD    = 3'd0,
    ALU_SUB    = 3'd1,
    ALU_AND    = 3'd2,
    ALU_OR     = 3'd3,
    ALU_XOR    = 3'd4,
    ALU_SLT    = 3'd5,
    ALU_SLTU   = 3'd6,
    ALU_PASS_B = 3'd7
  } alu_op_t;

  // Writeback source
  typedef enum logic [0:0] {
    WB_ALU  = 1'b0,
    WB_LINK = 1'b1
  } wb_sel_t;

  // Branch condition
  typedef enum logic [2:0] {
    BR_NONE = 3'd0,
    BR_EQ   = 3'd1,
    BR_NE   = 3'd2,
    BR_LT   = 3'd3,
    BR_GE   = 3'd4
  } br_cond_t;

  // --------------------
  // Major opcodes of the kept subset
  typedef enum logic [6:0] {
    OPC_OP     = 7'b0110011,
    OPC_OP_IMM = 7'b0010011,
    OPC_LUI    = 7'b0110111,
    OPC_JAL    = 7'b1101111,
    OPC_BRANCH = 7'b1100011
  } opcode_t;

endpackage

`default_nettype wire

// ==== hw/thread_fetch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module thread_fetch (
  input  wire                    clk,
  input  wire                    reset,
  // Next PC from writeback
  input  wire                    i_pc_wr_en,
  input  wire rv_pkg::thread_t   i_pc_wr_thread,
  input  wire rv_pkg::word_t     i_pc_wr_data,
  // ROM request
  output logic                   o_rom_en,
  output rv_pkg::thread_t        o_rom_thread,
  output rv_pkg::rom_addr_t      o_rom_addr,
  // Slot, aligned with the returning instruction
  output logic                   o_slot_valid,
  output rv_pkg::thread_t        o_slot_thread,
  output rv_pkg::word_t          o_slot_pc
);

  localparam int NT = `RV_NUM_THREADS;

  logic            start;
  rv_pkg::thread_t thread_cnt;
  rv_pkg::word_t   pc_table [NT];
  rv_pkg::word_t   cur_pc;

  // --------------------
  // Thread counter
  // start rises one cycle after reset release, first fetch is thread 0
  always_ff @(posedge clk) begin
    if (reset) begin
      start      <= 1'b0;
      thread_cnt <= '0;
    end else begin
      start <= 1'b1;
      // Power-of-two count, wraps on its own
      if (start) begin
        thread_cnt <= thread_cnt + 1'b1;
      end
    end
  end

  // --------------------
  // PC per thread
  always_ff @(posedge clk) begin
    if (reset) begin
      for (int t = 0; t < NT; t++) begin
        pc_table[t] <= '0;
      end
    end else if (i_pc_wr_en) begin
      pc_table[i_pc_wr_thread] <= i_pc_wr_data;
    end
  end

  assign cur_pc = pc_table[thread_cnt];

  // Word address within the thread region
  assign o_rom_en     = start;
  assign o_rom_thread = thread_cnt;
  assign o_rom_addr   = cur_pc[`RV_ROM_AW+1:2];

  // One cycle delay to meet the synchronous ROM data
  always_ff @(posedge clk) begin
    if (reset) begin
      o_slot_valid  <= 1'b0;
      o_slot_thread <= '0;
    end else begin
      o_slot_valid  <= start;
      o_slot_thread <= thread_cnt;
    end
  end

  always_ff @(posedge clk) begin
    o_slot_pc <= cur_pc;
  end

endmodule

`default_nettype wire

// ==== hw/thread_regfile.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module thread_regfile (
  input  wire                    clk,
  // Read side, decode cycle
  input  wire rv_pkg::thread_t   i_rd_thread,
  input  wire rv_pkg::reg_idx_t  i_rs1,
  input  wire rv_pkg::reg_idx_t  i_rs2,
  // Write side, from writeback
  input  wire                    i_wr_en,
  input  wire rv_pkg::thread_t   i_wr_thread,
  input  wire rv_pkg::reg_idx_t  i_wr_addr,
  input  wire rv_pkg::word_t     i_wr_data,
  output rv_pkg::word_t          o_rs1_data,
  output rv_pkg::word_t          o_rs2_data
);

  localparam int TW    = $clog2(`RV_NUM_THREADS);
  localparam int DEPTH = `RV_NUM_THREADS * 32;

  // Banked by thread, thread index in the upper address bits
  // All zero at start, x0 stays that way
  rv_pkg::word_t regs [DEPTH] = '{default: '0};

  logic [TW+4:0] rd1_idx;
  logic [TW+4:0] rd2_idx;
  logic [TW+4:0] wr_idx;

  assign rd1_idx = {i_rd_thread, i_rs1};
  assign rd2_idx = {i_rd_thread, i_rs2};
  assign wr_idx  = {i_wr_thread, i_wr_addr};

  // Single write port, x0 never written
  always_ff @(posedge clk) begin
    if (i_wr_en && (i_wr_addr != '0)) begin
      regs[wr_idx] <= i_wr_data;
    end
  end

  // Combinational reads
  assign o_rs1_data = regs[rd1_idx];
  assign o_rs2_data = regs[rd2_idx];

endmodule

`default_nettype wire

// ==== riscv_barrel_core.f ====
+incdir+hw
+incdir+tb
hw/rv_pkg.sv
hw/thread_fetch.sv
hw/thread_regfile.sv
hw/instr_decoder.sv
hw/execute_unit.sv
hw/riscv_barrel_core.sv
tb/tb_riscv_barrel_core.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal -f riscv_barrel_core.f \
  --top-module tb_riscv_barrel_core -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/sim_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^RESULT: PASS$'; then
  exit 0
fi
exit 1

// ==== tb/rv_ref_model.svh ====
`ifndef RV_REF_MODEL_SVH
`define RV_REF_MODEL_SVH

// Program image and architectural state per thread
logic [31:0] rng_state;
logic [31:0] rom_image [NT*ROM_WORDS];
logic [31:0] m_pc [NT];
logic [31:0] m_regs [NT][32];

// --------------------
// 32-bit xorshift
function automatic logic [31:0] xorshift32();
  logic [31:0] x;
  x = rng_state;
  x = x ^ (x << 13);
  x = x ^ (x >> 17);
  x = x ^ (x << 5);
  rng_state = x;
  return x;
endfunction

// Random instruction from the kept set, loads mixed in as no-ops
function automatic logic [31:0] random_instr();
  logic [31:0] r;
  logic [31:0] s;
  logic [4:0]  rd;
  logic [4:0]  rs1;
  logic [4:0]  rs2;
  logic [2:0]  f3;
  logic [12:0] boff;
  logic [20:0] joff;
  int          ow;
  logic [31:0] instr;
  r = xorshift32();
  s = xorshift32();
  // Only x0..x7, so results feed each other and x0 shows up often
  rd  = (r[2:0] == 3'd0) ? 5'd0 : {2'b00, r[5:3]};
  rs1 = {2'b00, r[8:6]};
  rs2 = {2'b00, r[11:9]};
  case (s[10:8])
    3'd1:    f3 = 3'b010;
    3'd2:    f3 = 3'b011;
    3'd3:    f3 = 3'b100;
    3'd4:    f3 = 3'b110;
    3'd5:    f3 = 3'b111;
    default: f3 = 3'b000;
  endcase
  if (s[3:0] < 4'd4) begin
    instr = {(f3 == 3'b000 && s[11]) ? 7'h20 : 7'h00, rs2, rs1, f3, rd, 7'b0110011};
  end else if (s[3:0] < 4'd8) begin
    instr = {r[31:20], rs1, f3, rd, 7'b0010011};
  end else if (s[3:0] < 4'd10) begin
    instr = {r[31:12], rd, 7'b0110111};
  end else if (s[3:0] < 4'd12) begin
    // JAL forward only, 1 to 16 words
    ow    = int'(s[7:4]) + 1;
    joff  = 21'(ow * 4);
    instr = {joff[20], joff[10:1], joff[11], joff[19:12], rd, 7'b1101111};
  end else if (s[3:0] < 4'd15) begin
    // Branches from -4 to +11 words, never onto itself
    ow = int'(s[7:4]) - 4;
    if (ow == 0) begin
      ow = 1;
    end
    boff  = 13'(ow * 4);
    instr = {boff[12], boff[10:5], rs2, rs1, {s[9], 1'b0, s[8]}, boff[4:1], boff[11],
             7'b1100011};
  end else begin
    instr = {r[31:20], rs1, 3'b010, rd, 7'b0000011};
  end
  return instr;
endfunction

task automatic fill_rom();
  for (int i = 0; i < NT * ROM_WORDS; i++) begin
    rom_image[i] = random_instr();
  end
endtask

task automatic reset_model();
  for (int t = 0; t < NT; t++) begin
    m_pc[t] = '0;
    for (int k = 0; k < 32; k++) begin
      m_regs[t][k] = '0;
    end
  end
endtask

// --------------------
// ALU per funct3, sub only for register ADD
function automatic logic [31:0] alu_result(input logic [2:0] f3, input logic sub,
                                           input logic [31:0] a, input logic [31:0] b);
  case (f3)
    3'b000:  return sub ? a - b : a + b;
    3'b010:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
    3'b011:  return (a < b) ? 32'd1 : 32'd0;
    3'b100:  return a ^ b;
    3'b110:  return a | b;
    3'b111:  return a & b;
    default: return 32'd0;
  endcase
endfunction

// One instruction of thread t, returns the expected writeback
task automatic step_model(input int t, output logic en, output logic [4:0] rd,
                          output logic [31:0] data);
  logic [31:0] pc;
  logic [31:0] instr;
  logic [31:0] a;
  logic [31:0] b;
  logic [31:0] imm_i;
  logic [31:0] imm_b;
  logic [31:0] imm_j;
  logic [31:0] next_pc;
  logic [2:0]  f3;
  logic [6:0]  f7;
  logic        taken;
  pc      = m_pc[t];
  instr   = rom_image[t * ROM_WORDS + int'(pc[`RV_ROM_AW+1:2])];
  rd      = instr[11:7];
  f3      = instr[14:12];
  f7      = instr[31:25];
  a       = m_regs[t][instr[19:15]];
  b       = m_regs[t][instr[24:20]];
  imm_i   = {{20{instr[31]}}, instr[31:20]};
  imm_b   = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
  imm_j   = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
  next_pc = pc + 32'd4;
  en      = 1'b0;
  data    = 32'd0;
  taken   = 1'b0;
  case (instr[6:0])
    7'b0110011: begin
      // Base funct7, plus SUB
      if (f7 == 7'h00 || (f7 == 7'h20 && f3 == 3'b000)) begin
        en   = (f3 != 3'b001) && (f3 != 3'b101);
        data = alu_result(f3, f7[5], a, b);
      end
    end
    7'b0010011: begin
      en   = (f3 != 3'b001) && (f3 != 3'b101);
      data = alu_result(f3, 1'b0, a, imm_i);
    end
    7'b0110111: begin
      en   = 1'b1;
      data = {instr[31:12], 12'd0};
    end
    7'b1101111: begin
      en      = 1'b1;
      data    = pc + 32'd4;
      next_pc = pc + imm_j;
    end
    7'b1100011: begin
      case (f3)
        3'b000:  taken = (a == b);
        3'b001:  taken = (a != b);
        3'b100:  taken = ($signed(a) < $signed(b));
        3'b101:  taken = ($signed(a) >= $signed(b));
        default: taken = 1'b0;
      endcase
      if (taken) begin
        next_pc = pc + imm_b;
      end
    end
    default: en = 1'b0;
  endcase
  // x0 is never written
  if (rd == 5'd0) begin
    en = 1'b0;
  end
  if (en) begin
    m_regs[t][rd] = data;
  end
  m_pc[t] = next_pc;
endtask

`endif

// ==== tb/tb_riscv_barrel_core.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "rv_defs.svh"

module tb_riscv_barrel_core;

  localparam int NT           = `RV_NUM_THREADS;
  localparam int TW           = $clog2(NT);
  localparam int ROM_WORDS    = 1 << `RV_ROM_AW;
  localparam int RESET_CYCLES = 5;
  localparam int NUM_SLOTS    = 2000;
  localparam int WB_LATENCY   = 3;
  localparam int CYCLE_LIMIT  = NUM_SLOTS + RESET_CYCLES + 20;

  // Expected writeback, due a fixed number of cycles after its fetch
  typedef struct packed {
    int            due;
    logic [TW-1:0] thread;
    logic          en;
    logic [4:0]    rd;
    logic [31:0]   data;
  } wb_exp_t;

  logic              clk;
  logic              reset;
  rv_pkg::word_t     rom_instr;
  logic              rom_en;
  rv_pkg::thread_t   rom_thread;
  rv_pkg::rom_addr_t rom_addr;
  logic              wb_en;
  rv_pkg::thread_t   wb_thread;
  rv_pkg::reg_idx_t  wb_addr;
  rv_pkg::word_t     wb_data;

  int      errors;
  int      checks;
  wb_exp_t exp_q[$];

  `include "rv_ref_model.svh"

  riscv_barrel_core i_dut (
    .clk          (clk),
    .reset        (reset),
    .i_rom_instr  (rom_instr),
    .o_rom_en     (rom_en),
    .o_rom_thread (rom_thread),
    .o_rom_addr   (rom_addr),
    .o_wb_en      (wb_en),
    .o_wb_thread  (wb_thread),
    .o_wb_addr    (wb_addr),
    .o_wb_data    (wb_data)
  );

  initial begin : clock_gen
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    checks++;
    if (actual !== expected) begin
      errors++;
      $display("[FAIL] %s at %0t: got 0x%h, expected 0x%h", name, $time, actual, expected);
    end
  endtask

  // --------------------
  // Stimulus and checks, all on the falling edge
  initial begin : stimulus
    int                       n;
    int                       wb_seen;
    int                       exp_thread;
    logic                     fetch_pend;
    logic [TW+`RV_ROM_AW-1:0] pend_idx;
    logic                     exp_en;
    logic [4:0]               exp_rd;
    logic [31:0]              exp_data;
    wb_exp_t                  e;
    reset      = 1'b1;
    rom_instr  = '0;
    errors     = 0;
    checks     = 0;
    rng_state  = 32'd83511;
    fill_rom();
    reset_model();
    n          = 0;
    wb_seen    = 0;
    exp_thread = 0;
    fetch_pend = 1'b0;
    pend_idx   = '0;
    while (wb_seen < NUM_SLOTS) begin
      @(negedge clk);
      n++;
      // Writeback side
      if (exp_q.size() > 0 && exp_q[0].due == n) begin
        e = exp_q.pop_front();
        check_value("o_wb_thread", 32'(wb_thread), 32'(e.thread));
        check_value("o_wb_en", 32'(wb_en), 32'(e.en));
        if (e.en) begin
          check_value("o_wb_addr", 32'(wb_addr), 32'(e.rd));
          check_value("o_wb_data", wb_data, e.data);
        end
        wb_seen++;
      end else begin
        check_value("o_wb_en", 32'(wb_en), 32'd0);
      end
      // Fetch side, first fetch right after the first cycle out of reset
      check_value("o_rom_en", 32'(rom_en), 32'(n > RESET_CYCLES));
      if (rom_en === 1'b1) begin
        check_value("o_rom_thread", 32'(rom_thread), 32'(exp_thread));
        check_value("o_rom_addr", 32'(rom_addr), 32'(m_pc[exp_thread][`RV_ROM_AW+1:2]));
        step_model(exp_thread, exp_en, exp_rd, exp_data);
        e.due    = n + WB_LATENCY;
        e.thread = TW'(exp_thread);
        e.en     = exp_en;
        e.rd     = exp_rd;
        e.data   = exp_data;
        exp_q.push_back(e);
        exp_thread = (exp_thread + 1) % NT;
      end
      // Synchronous ROM, data for the previous cycle's fetch
      rom_instr  = fetch_pend ? rom_image[pend_idx] : '0;
      fetch_pend = rom_en;
      pend_idx   = {rom_thread, rom_addr};
      if (n == RESET_CYCLES) begin
        reset = 1'b0;
      end
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("RESULT: PASS");
    end else begin
      $display("RESULT: FAIL");
    end
    $finish;
  end

  // Run limit in clock cycles
  initial begin : watchdog
    int cycles;
    cycles = 0;
    while (cycles < CYCLE_LIMIT) begin
      @(posedge clk);
      cycles++;
    end
    $display("Timeout: the run did not end within %0d cycles", CYCLE_LIMIT);
    $display("RESULT: FAIL");
    $finish;
  end

endmodule

`default_nettype wire
